/* cmd_packet_rx.f */
+incdir+include
hdl/cmd_packet_rx_pkg.sv
hdl/uart_rx.sv
hdl/pkt_buffer.sv
hdl/crc32_engine.sv
hdl/rx_frame_ctrl.sv
hdl/cmd_packet_rx.sv
verification/tb_cmd_packet_rx.sv

/* hdl/cmd_packet_rx.sv */
`timescale 1ns/100ps

module cmd_packet_rx #(
    parameter int clks_per_bit   = 434,
    parameter int line_idle_clks = 6510
) (
    input  logic                          i_clk,
    input  logic                          i_n_reset,
    input  logic                          i_uart_rx,
    input  cmd_packet_rx_pkg::pkt_addr_t  i_rd_addr,
    output logic [7:0]                    o_rd_data,
    output cmd_packet_rx_pkg::rx_status_t o_status
);

    import cmd_packet_rx_pkg::*;

    uart_byte_t  rx_byte;
    logic        wr_en;
    pkt_addr_t   wr_addr;
    logic [7:0]  wr_data;
    pkt_addr_t   ctrl_rd_addr;
    logic [7:0]  ctrl_rd_data;
    logic        crc_init_pulse;
    logic        crc_byte_valid;
    logic [7:0]  crc_byte;
    logic [31:0] crc_value;

    uart_rx #(
        .clks_per_bit (clks_per_bit)
    ) u_uart_rx (
        .i_clk     (i_clk),
        .i_n_reset (i_n_reset),
        .i_serial  (i_uart_rx),
        .o_byte    (rx_byte)
    );

    rx_frame_ctrl #(
        .line_idle_clks (line_idle_clks)
    ) u_rx_frame_ctrl (
        .i_clk       (i_clk),
        .i_n_reset   (i_n_reset),
        .i_byte      (rx_byte),
        .o_wr_en     (wr_en),
        .o_wr_addr   (wr_addr),
        .o_wr_data   (wr_data),
        .o_rd_addr   (ctrl_rd_addr),
        .i_rd_data   (ctrl_rd_data),
        .o_crc_init  (crc_init_pulse),
        .o_crc_valid (crc_byte_valid),
        .o_crc_data  (crc_byte),
        .i_crc       (crc_value),
        .o_status    (o_status)
    );

    pkt_buffer u_pkt_buffer (
        .i_clk       (i_clk),
        .i_wr_en     (wr_en),
        .i_wr_addr   (wr_addr),
        .i_wr_data   (wr_data),
        .i_rd_addr_a (ctrl_rd_addr),
        .o_rd_data_a (ctrl_rd_data),
        .i_rd_addr_b (i_rd_addr),
        .o_rd_data_b (o_rd_data)
    );

    crc32_engine u_crc32_engine (
        .i_clk     (i_clk),
        .i_n_reset (i_n_reset),
        .i_init    (crc_init_pulse),
        .i_valid   (crc_byte_valid),
        .i_data    (crc_byte),
        .o_crc     (crc_value)
    );

endmodule

/* hdl/cmd_packet_rx_pkg.sv */
package cmd_packet_rx_pkg;

    localparam int pkt_max_len = 64;    // buffer depth in bytes
    localparam int crc_len     = 4;     // trailer bytes
    localparam int min_pkt_len = 5;     // one body byte plus trailer

    localparam logic [31:0] crc_init    = 32'hFFFF_FFFF;
    localparam logic [31:0] crc_poly    = 32'hEDB8_8320;   // reflected 0x04C11DB7
    localparam logic [31:0] crc_xor_out = 32'hFFFF_FFFF;

    // buffer address, also used as packet length
    typedef logic [5:0] pkt_addr_t;

    typedef struct packed {
        logic       strobe;     // one cycle per received byte
        logic [7:0] data;
    } uart_byte_t;

    typedef struct packed {
        logic      new_pkt;     // good packet, one cycle
        logic      busy;
        pkt_addr_t len;
    } rx_status_t;

    // trailer arrives LSB first, byte 0 is bits 7..0
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] bytes;
    } crc_word_u;

endpackage

/* hdl/crc32_engine.sv */
`timescale 1ns/100ps

module crc32_engine (
    input  logic        i_clk,
    input  logic        i_n_reset,
    input  logic        i_init,
    input  logic        i_valid,
    input  logic [7:0]  i_data,
    output logic [31:0] o_crc
);

    import cmd_packet_rx_pkg::*;

    logic [31:0] crc_q;

    // eight shift steps of the reflected polynomial
    function automatic logic [31:0] crc_step(
        input logic [31:0] crc,
        input logic [7:0]  data
    );
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ crc_poly) : (c >> 1);
        end
        return c;
    endfunction

    always_ff @(posedge i_clk or negedge i_n_reset) begin
        if (!i_n_reset) begin
            crc_q <= crc_init;
        end else if (i_init) begin
            crc_q <= crc_init;
        end else if (i_valid) begin
            crc_q <= crc_step(crc_q, i_data);
        end
    end

    assign o_crc = crc_q ^ crc_xor_out;

    init_valid_excl: assert property (@(posedge i_clk) disable iff (!i_n_reset)
        !(i_init && i_valid));

endmodule

/* hdl/pkt_buffer.sv */
`timescale 1ns/100ps

module pkt_buffer (
    input  logic                         i_clk,
    input  logic                         i_wr_en,
    input  cmd_packet_rx_pkg::pkt_addr_t i_wr_addr,
    input  logic [7:0]                   i_wr_data,
    input  cmd_packet_rx_pkg::pkt_addr_t i_rd_addr_a,
    output logic [7:0]                   o_rd_data_a,
    input  cmd_packet_rx_pkg::pkt_addr_t i_rd_addr_b,
    output logic [7:0]                   o_rd_data_b
);

    import cmd_packet_rx_pkg::*;

    logic [7:0] mem [pkt_max_len];

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // port a for the controller
    always_ff @(posedge i_clk) begin
        o_rd_data_a <= mem[i_rd_addr_a];
    end

    // port b for the external reader
    always_ff @(posedge i_clk) begin
        o_rd_data_b <= mem[i_rd_addr_b];
    end

endmodule

/* hdl/rx_frame_ctrl.sv */
`timescale 1ns/100ps

module rx_frame_ctrl #(
    parameter int line_idle_clks = 6510
) (
    input  logic                          i_clk,
    input  logic                          i_n_reset,
    input  cmd_packet_rx_pkg::uart_byte_t i_byte,
    output logic                          o_wr_en,
    output cmd_packet_rx_pkg::pkt_addr_t  o_wr_addr,
    output logic [7:0]                    o_wr_data,
    output cmd_packet_rx_pkg::pkt_addr_t  o_rd_addr,
    input  logic [7:0]                    i_rd_data,
    output logic                          o_crc_init,
    output logic                          o_crc_valid,
    output logic [7:0]                    o_crc_data,
    input  logic [31:0]                   i_crc,
    output cmd_packet_rx_pkg::rx_status_t o_status
);

    import cmd_packet_rx_pkg::*;

    localparam int tmr_w = $clog2(line_idle_clks + 1);
    localparam logic [tmr_w-1:0] gap_last = tmr_w'(line_idle_clks - 1);

    localparam logic [2:0] st_idle    = 3'd0;
    localparam logic [2:0] st_collect = 3'd1;
    localparam logic [2:0] st_crc     = 3'd2;
    localparam logic [2:0] st_trailer = 3'd3;
    localparam logic [2:0] st_check   = 3'd4;

    logic [2:0]       state;
    pkt_addr_t        len;
    logic             ovf;
    logic [tmr_w-1:0] gap_cnt;
    pkt_addr_t        rd_addr;
    pkt_addr_t        body_last;
    logic             len_full;
    logic [1:0]       trl_cnt;
    logic [1:0]       trl_idx_q;
    logic             rd_body_q;   // body byte arrives next cycle
    logic             rd_trl_q;    // trailer byte arrives next cycle
    logic             crc_init_q;
    logic             new_q;
    crc_word_u        trailer;

    assign body_last = len - pkt_addr_t'(crc_len + 1);
    assign len_full  = (len == '1);

    // first byte goes to address 0, later ones at the running length
    assign o_wr_en   = i_byte.strobe &&
                       (state == st_idle || (state == st_collect && !len_full));
    assign o_wr_addr = (state == st_idle) ? '0 : len;
    assign o_wr_data = i_byte.data;

    assign o_rd_addr   = rd_addr;
    assign o_crc_init  = crc_init_q;
    assign o_crc_valid = rd_body_q;
    assign o_crc_data  = i_rd_data;

    assign o_status.new_pkt = new_q;
    assign o_status.busy    = (state != st_idle);
    assign o_status.len     = len;

    always_ff @(posedge i_clk or negedge i_n_reset) begin
        if (!i_n_reset) begin
            state      <= st_idle;
            len        <= '0;
            ovf        <= 1'b0;
            gap_cnt    <= '0;
            rd_addr    <= '0;
            trl_cnt    <= '0;
            trl_idx_q  <= '0;
            rd_body_q  <= 1'b0;
            rd_trl_q   <= 1'b0;
            crc_init_q <= 1'b0;
            new_q      <= 1'b0;
        end else begin
            crc_init_q <= 1'b0;
            new_q      <= 1'b0;
            rd_body_q  <= 1'b0;
            rd_trl_q   <= 1'b0;
            case (state)
                st_idle: begin
                    if (i_byte.strobe) begin
                        len     <= pkt_addr_t'(1);
                        ovf     <= 1'b0;
                        gap_cnt <= '0;
                        state   <= st_collect;
                    end
                end
                st_collect: begin
                    if (i_byte.strobe) begin
                        gap_cnt <= '0;
                        if (len_full) begin
                            ovf <= 1'b1;   // 64th byte, packet is lost
                        end else begin
                            len <= len + 1'b1;
                        end
                    end else if (gap_cnt == gap_last) begin
                        gap_cnt <= '0;
                        if (ovf || len < pkt_addr_t'(min_pkt_len)) begin
                            state <= st_idle;
                        end else begin
                            rd_addr    <= '0;
                            crc_init_q <= 1'b1;
                            state      <= st_crc;
                        end
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                st_crc: begin
                    rd_body_q <= 1'b1;
                    rd_addr   <= rd_addr + 1'b1;
                    trl_cnt   <= '0;
                    if (rd_addr == body_last) begin
                        state <= st_trailer;
                    end
                end
                st_trailer: begin
                    rd_trl_q  <= 1'b1;
                    trl_idx_q <= trl_cnt;
                    rd_addr   <= rd_addr + 1'b1;
                    trl_cnt   <= trl_cnt + 1'b1;
                    if (trl_cnt == 2'd3) begin
                        state <= st_check;
                    end
                end
                st_check: begin
                    // wait for the last trailer byte to land
                    if (!rd_trl_q) begin
                        new_q <= (trailer.word == i_crc);
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (rd_trl_q) begin
            trailer.bytes[trl_idx_q] <= i_rd_data;
        end
    end

    new_len_ok: assert property (@(posedge i_clk) disable iff (!i_n_reset)
        new_q |-> (len >= pkt_addr_t'(min_pkt_len)));

endmodule

/* hdl/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx #(
    parameter int clks_per_bit = 434
) (
    input  logic                          i_clk,
    input  logic                          i_n_reset,
    input  logic                          i_serial,
    output cmd_packet_rx_pkg::uart_byte_t o_byte
);

    localparam int cnt_w = $clog2(clks_per_bit + 1);
    localparam logic [cnt_w-1:0] bit_last  = cnt_w'(clks_per_bit - 1);
    localparam logic [cnt_w-1:0] half_last = cnt_w'(clks_per_bit / 2 - 1);

    localparam logic [2:0] st_idle  = 3'd0;
    localparam logic [2:0] st_start = 3'd1;
    localparam logic [2:0] st_data  = 3'd2;
    localparam logic [2:0] st_stop  = 3'd3;
    localparam logic [2:0] st_tail  = 3'd4;   // rest of stop bit

    logic [1:0]       rx_sync;
    logic             rx_bit;
    logic [2:0]       state;
    logic [cnt_w-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_q;
    logic             strobe_q;

    assign rx_bit = rx_sync[1];

    always_ff @(posedge i_clk or negedge i_n_reset) begin
        if (!i_n_reset) begin
            rx_sync  <= 2'b11;   // line idles high
            state    <= st_idle;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            strobe_q <= 1'b0;
        end else begin
            rx_sync  <= {rx_sync[0], i_serial};
            strobe_q <= 1'b0;
            case (state)
                st_idle: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!rx_bit) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    if (clk_cnt == half_last) begin
                        clk_cnt <= '0;
                        state   <= rx_bit ? st_idle : st_data;   // short glitch dropped
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (clk_cnt == bit_last) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= st_stop;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                st_stop: begin
                    if (clk_cnt == bit_last) begin
                        clk_cnt <= '0;
                        state   <= rx_bit ? st_tail : st_idle;   // framing error drops the byte
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                st_tail: begin
                    if (clk_cnt == half_last) begin
                        strobe_q <= 1'b1;
                        state    <= st_idle;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == st_data && clk_cnt == bit_last) begin
            shift_q <= {rx_bit, shift_q[7:1]};   // lsb first
        end
    end

    assign o_byte.strobe = strobe_q;
    assign o_byte.data   = shift_q;

    strobe_single: assert property (@(posedge i_clk) disable iff (!i_n_reset)
        o_byte.strobe |=> !o_byte.strobe);

endmodule

/* include/tb_pkt_tasks.svh */
// compare and count, nothing else
task automatic check_value(input string test_name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
        error_count++;
        $display("FAIL %s: expected 0x%0h, actual 0x%0h", test_name, expected, actual);
    end
endtask

// one 8N1 frame plus an idle bit, so the receiver is back in idle
task automatic drive_serial_byte(input logic [7:0] value);
    logic [10:0] frame;
    frame = {2'b11, value, 1'b0};    // bit 0 is the start bit
    for (int i = 0; i < frame_bits; i++) begin
        @(posedge clk);
        uart_line <= frame[i];
        repeat (bit_clks - 1) @(posedge clk);
    end
endtask

// bit-serial reflected crc-32 over sent_bytes[0..n-1]
function automatic logic [31:0] ref_crc32(input int n);
    logic [31:0] lfsr;
    logic        fb;
    lfsr = 32'hFFFF_FFFF;
    for (int i = 0; i < n; i++) begin
        for (int b = 0; b < 8; b++) begin
            fb   = lfsr[0] ^ sent_bytes[i][b];
            lfsr = lfsr >> 1;
            if (fb) begin
                lfsr = lfsr ^ 32'hEDB8_8320;
            end
        end
    end
    return ~lfsr;
endfunction

task automatic send_packet(input int len, input logic corrupt,
                           output int new_count, output logic busy_seen);
    logic [31:0] crc;
    logic [31:0] rnd;
    int          body;
    int          cycles;
    logic        done;
    body = len - 4;
    for (int i = 0; i < body; i++) begin
        rnd           = $random(seed);
        sent_bytes[i] = rnd[7:0];
    end
    crc = ref_crc32(body);
    if (corrupt) begin
        crc = crc ^ 32'h0000_0100;
    end
    for (int i = 0; i < 4; i++) begin
        sent_bytes[body + i] = crc[8*i +: 8];    // trailer lsb first
    end
    if (len >= pkt_max_len) begin
        // stored 63 bytes carry a good trailer, only the overflow mark rejects them
        crc = ref_crc32(pkt_max_len - 5);
        for (int i = 0; i < 4; i++) begin
            sent_bytes[pkt_max_len - 5 + i] = crc[8*i +: 8];
        end
    end
    for (int i = 0; i < len; i++) begin
        drive_serial_byte(sent_bytes[i]);
    end
    new_count = 0;
    cycles    = 0;
    done      = 1'b0;
    @(negedge clk);
    busy_seen = status.busy;
    while (!done) begin
        if (status.new_pkt) begin
            new_count++;
        end
        if (!status.busy) begin
            done = 1'b1;
        end else if (cycles == wait_limit) begin
            $display("timeout: busy still high %0d cycles after the last byte", cycles);
            error_count++;
            done = 1'b1;
        end else begin
            cycles++;
            @(negedge clk);
        end
    end
    repeat (2) begin    // a pulse must not linger
        @(negedge clk);
        if (status.new_pkt) begin
            new_count++;
        end
    end
endtask

// registered read port, data one cycle after the address
task automatic read_back(input string test_name, input int len);
    for (int a = 0; a < len; a++) begin
        @(posedge clk);
        rd_addr <= pkt_addr_t'(a);
        @(posedge clk);
        @(negedge clk);
        check_value($sformatf("%s_byte%0d", test_name, a),
                    {24'd0, sent_bytes[a]}, {24'd0, rd_data});
    end
endtask

/* verification/tb_cmd_packet_rx.sv */
`timescale 1ns/100ps

module tb_cmd_packet_rx;

    import cmd_packet_rx_pkg::*;

    localparam int bit_clks   = 16;
    localparam int idle_clks  = 400;
    localparam int frame_bits = 11;    // start, 8 data, stop, one idle bit
    localparam int wait_limit = idle_clks + 2 * pkt_max_len + 50;
    localparam int n_cases    = 7;

    typedef struct packed {
        int   len;
        logic corrupt;    // flip one trailer bit
        logic accept;     // new pulse expected
    } pkt_case_t;

    logic       clk;
    logic       n_reset;
    logic       uart_line;
    pkt_addr_t  rd_addr;
    logic [7:0] rd_data;
    rx_status_t status;

    integer     seed = 31;
    int         error_count = 0;
    logic [7:0] sent_bytes [128];

    string case_name [n_cases] = '{
        "min_len_5", "len_12", "len_63", "bad_crc", "short_4", "overflow_70", "after_ovf"
    };

    pkt_case_t case_tab [n_cases] = '{
        '{5,  1'b0, 1'b1},
        '{12, 1'b0, 1'b1},
        '{63, 1'b0, 1'b1},
        '{12, 1'b1, 1'b0},
        '{4,  1'b0, 1'b0},
        '{70, 1'b0, 1'b0},
        '{20, 1'b0, 1'b1}
    };

    `include "tb_pkt_tasks.svh"

    cmd_packet_rx #(
        .clks_per_bit   (bit_clks),
        .line_idle_clks (idle_clks)
    ) dut0 (
        .i_clk     (clk),
        .i_n_reset (n_reset),
        .i_uart_rx (uart_line),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data),
        .o_status  (status)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin : stimulus
        int        new_count;
        logic      busy_seen;
        pkt_case_t tc;
        n_reset   = 1'b0;
        uart_line = 1'b1;    // line idles high
        rd_addr   = '0;
        repeat (16) @(posedge clk);
        n_reset <= 1'b1;
        @(negedge clk);
        check_value("reset_busy", 32'd0, {31'd0, status.busy});
        check_value("reset_new", 32'd0, {31'd0, status.new_pkt});
        check_value("reset_len", 32'd0, {26'd0, status.len});

        // known check value of the reference model
        for (int i = 0; i < 9; i++) begin
            sent_bytes[i] = 8'h31 + i[7:0];
        end
        check_value("crc_reference", 32'hCBF4_3926, ref_crc32(9));

        for (int k = 0; k < n_cases; k++) begin
            tc = case_tab[k];
            send_packet(tc.len, tc.corrupt, new_count, busy_seen);
            check_value({case_name[k], "_busy"}, 32'd1, {31'd0, busy_seen});
            check_value({case_name[k], "_new"}, {31'd0, tc.accept}, new_count);
            if (tc.accept) begin
                check_value({case_name[k], "_len"}, tc.len, {26'd0, status.len});
                read_back(case_name[k], tc.len);
            end
        end

        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        limit = 300;    // reset and start-up
        for (int k = 0; k < n_cases; k++) begin
            limit += case_tab[k].len * frame_bits * bit_clks;
            limit += idle_clks + 3 * case_tab[k].len + 300;
        end
        repeat (limit) @(posedge clk);
        $display("watchdog: run did not finish within %0d clock cycles", limit);
        $display("Verification failed");
        $finish;
    end

endmodule
